// ==== verilog/icache_pkg.sv ====
package icache_pkg;

    // ------------------------------------------------------------------------
    // Address layout
    // ------------------------------------------------------------------------
    localparam int addr_width   = 32;
    localparam int offset_width = 4;
    localparam int index_width  = 2;
    localparam int tag_width    = addr_width - index_width - offset_width;

    // Line geometry, four 32-bit words per line
    localparam int line_words = 4;
    localparam int line_width = line_words * 32;

    // ------------------------------------------------------------------------
    // Cache controller states
    // ------------------------------------------------------------------------
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_lookup  = 2'd1;
    localparam logic [1:0] st_refill  = 2'd2;
    localparam logic [1:0] st_respond = 2'd3;

    // Field view of a fetch address, MSB first
    typedef struct packed {
        logic [tag_width-1:0]          tag;
        logic [index_width-1:0]        index;
        logic [$clog2(line_words)-1:0] word;
        logic [1:0]                    byte_sel;
    } fetch_fields_t;

    // Same word read as a plain byte address or as lookup fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        fetch_fields_t         f;
    } fetch_addr_t;

endpackage

// ==== verilog/fetch_sequencer.sv ====
`timescale 1ns/1ps

module fetch_sequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    run,
    input  logic                    redirect,
    input  icache_pkg::fetch_addr_t redirect_pc,
    output logic                    fetch_valid,
    output icache_pkg::fetch_addr_t fetch_addr,
    input  logic                    fetch_ready
);
    import icache_pkg::*;

    fetch_addr_t target_pc;
    logic        accept;

    assign accept = fetch_valid && fetch_ready;

    // Redirect target forced onto a word boundary
    always_comb begin
        target_pc = redirect_pc;
        target_pc.f.byte_sel = 2'b00;
    end

    // ------------------------------------------------------------------------
    // PC and request flag
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fetch_valid <= 1'b0;
            fetch_addr  <= '0;
        end else begin
            // An unaccepted request is kept even if run drops
            fetch_valid <= run || (fetch_valid && !fetch_ready);

            if (redirect) begin
                fetch_addr <= target_pc;
            end else if (accept) begin
                fetch_addr.raw <= fetch_addr.raw + 32'd4;
            end
        end
    end

    // Request and its address hold while the cache stalls, except on a redirect
    property p_addr_stable;
        @(posedge clock) disable iff (reset)
        (fetch_valid && !fetch_ready && !redirect) |=> (fetch_valid && $stable(fetch_addr));
    endproperty

    a_addr_stable: assert property (p_addr_stable)
        else $error("fetch request dropped or changed while pending");

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                flush,
    input  logic                                fetch_valid,
    input  icache_pkg::fetch_addr_t             fetch_addr,
    output logic                                fetch_ready,
    output logic                                line_valid,
    output logic [icache_pkg::line_width-1:0]   line_data,
    output icache_pkg::fetch_addr_t             line_addr,
    input  logic                                line_ready,
    output logic                                mem_arvalid,
    output logic [31:0]                         mem_araddr,
    input  logic                                mem_arready,
    input  logic                                mem_rvalid,
    input  logic [31:0]                         mem_rdata,
    input  logic                                mem_rlast,
    output logic                                mem_rready,
    output logic [31:0]                         hit_count,
    output logic [31:0]                         miss_count
);
    import icache_pkg::*;

    logic [1:0]                    state;
    logic                          flush_pending;
    logic                          hit_r;
    logic [$clog2(line_words)-1:0] beat_count;
    logic [2**index_width-1:0]     valid_array;
    logic [tag_width-1:0]          tag_array [2**index_width];
    logic [line_width-1:0]         data_array [2**index_width];
    logic                          accept;
    logic                          beat;
    logic                          lookup_hit;

    assign fetch_ready = (state == st_idle) && !flush_pending;
    assign accept      = fetch_valid && fetch_ready;
    assign beat        = mem_rvalid && mem_rready;
    assign lookup_hit  = valid_array[fetch_addr.f.index]
                         && (tag_array[fetch_addr.f.index] == fetch_addr.f.tag);

    assign line_valid = (state == st_respond);
    assign line_data  = data_array[line_addr.f.index];
    assign mem_rready = (state == st_refill);
    assign mem_araddr = {line_addr.f.tag, line_addr.f.index, {offset_width{1'b0}}};

    // ------------------------------------------------------------------------
    // Controller
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            hit_r <= 1'b0;
        end else begin
            if (accept) begin
                hit_r <= lookup_hit;
            end
            case (state)
                st_idle:    if (accept) state <= st_lookup;
                st_lookup:  state <= hit_r ? st_respond : st_refill;
                st_refill:  if (beat && mem_rlast) state <= st_respond;
                st_respond: if (line_ready) state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // Read address request, raised on a miss and held until taken
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mem_arvalid <= 1'b0;
            beat_count  <= '0;
        end else begin
            if (state == st_lookup && !hit_r) begin
                mem_arvalid <= 1'b1;
            end else if (mem_arvalid && mem_arready) begin
                mem_arvalid <= 1'b0;
            end

            if (state == st_lookup) begin
                beat_count <= '0;
            end else if (beat) begin
                beat_count <= beat_count + 1'b1;
            end
        end
    end

    // Valid bits and deferred flush
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_array   <= '0;
            flush_pending <= 1'b0;
        end else begin
            if (state == st_idle && flush_pending) begin
                valid_array <= '0;
            end else if (accept) begin
                valid_array[fetch_addr.f.index] <= 1'b1;
            end
            flush_pending <= flush || (flush_pending && state != st_idle);
        end
    end

    // Tag written at acceptance, one word per refill beat
    always_ff @(posedge clock) begin
        if (accept) begin
            line_addr <= fetch_addr;
            tag_array[fetch_addr.f.index] <= fetch_addr.f.tag;
        end
        if (beat) begin
            data_array[line_addr.f.index][beat_count*32 +: 32] <= mem_rdata;
        end
    end

    // ------------------------------------------------------------------------
    // Performance counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else if (state == st_lookup) begin
            if (hit_r) begin
                hit_count <= hit_count + 32'd1;
            end else begin
                miss_count <= miss_count + 32'd1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checks on the memory and consumer sides
    // ------------------------------------------------------------------------
    a_beat_in_refill: assert property (
        @(posedge clock) disable iff (reset)
        mem_rvalid |-> (state == st_refill))
        else $error("memory beat outside refill");

    // Last flag must coincide with the fourth beat
    a_last_on_fourth: assert property (
        @(posedge clock) disable iff (reset)
        beat |-> (mem_rlast == (beat_count == line_words - 1)))
        else $error("mem_rlast not on the final beat");

    // Line and its address held until the consumer takes them
    a_line_held: assert property (
        @(posedge clock) disable iff (reset)
        (line_valid && !line_ready)
        |=> (line_valid && $stable(line_data) && $stable(line_addr)))
        else $error("line changed or dropped without a transfer");

endmodule

// ==== verilog/inst_select.sv ====
`timescale 1ns/1ps

module inst_select (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              line_valid,
    input  logic [icache_pkg::line_width-1:0] line_data,
    input  icache_pkg::fetch_addr_t           line_addr,
    output logic                              line_ready,
    output logic                              inst_valid,
    output logic [31:0]                       inst,
    output logic [31:0]                       inst_pc,
    input  logic                              inst_ready
);
    import icache_pkg::*;

    logic [line_words-1:0][31:0] words;
    logic                        take;

    // Word 0 sits in the low bits of the line
    assign words = line_data;

    // Space when empty or draining this cycle
    assign line_ready = !inst_valid || inst_ready;
    assign take       = line_valid && line_ready;

    // ------------------------------------------------------------------------
    // Output register toward the downstream stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (take) begin
            inst_valid <= 1'b1;
        end else if (inst_ready) begin
            inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            inst    <= words[line_addr.f.word];
            inst_pc <= line_addr.raw;
        end
    end

endmodule

// ==== verilog/icache_subsystem.sv ====
`timescale 1ns/1ps

module icache_subsystem (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    run,
    input  logic                    redirect,
    input  icache_pkg::fetch_addr_t redirect_pc,
    input  logic                    flush,
    output logic                    mem_arvalid,
    output logic [31:0]             mem_araddr,
    input  logic                    mem_arready,
    input  logic                    mem_rvalid,
    input  logic [31:0]             mem_rdata,
    input  logic                    mem_rlast,
    output logic                    mem_rready,
    output logic                    inst_valid,
    output logic [31:0]             inst,
    output logic [31:0]             inst_pc,
    input  logic                    inst_ready,
    output logic [31:0]             hit_count,
    output logic [31:0]             miss_count
);
    import icache_pkg::*;

    // Sequencer to cache
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_addr_t fetch_addr;

    // Cache to word select
    logic                  line_valid;
    logic                  line_ready;
    logic [line_width-1:0] line_data;
    fetch_addr_t           line_addr;

    fetch_sequencer u_fetch_sequencer (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready)
    );

    icache u_icache (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .line_valid  (line_valid),
        .line_data   (line_data),
        .line_addr   (line_addr),
        .line_ready  (line_ready),
        .mem_arvalid (mem_arvalid),
        .mem_araddr  (mem_araddr),
        .mem_arready (mem_arready),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .mem_rlast   (mem_rlast),
        .mem_rready  (mem_rready),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    inst_select u_inst_select (
        .clock      (clock),
        .reset      (reset),
        .line_valid (line_valid),
        .line_data  (line_data),
        .line_addr  (line_addr),
        .line_ready (line_ready),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_ready (inst_ready)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    localparam int half_period  = 10;
    localparam int reset_cycles = 8;

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // Reset released just after the eighth rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== sim/tb_icache_subsystem.sv ====
`timescale 1ns/1ps

module tb_icache_subsystem;
    import icache_pkg::*;

    localparam int total_insts  = 120;
    localparam int clock_period = 20;

    logic        clock;
    logic        reset;
    logic        run;
    logic        redirect;
    fetch_addr_t redirect_pc;
    logic        flush;
    logic        mem_arvalid;
    logic [31:0] mem_araddr;
    logic        mem_arready;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic        mem_rlast;
    logic        mem_rready;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        inst_ready;
    logic [31:0] hit_count;
    logic [31:0] miss_count;

    logic [31:0] lfsr;
    logic        stress;
    logic [31:0] exp_pc;
    int          seen;
    int          errors;
    int          err_mark;
    int          exp_hits;
    int          exp_misses;

    tb_clock_gen u_tb_clock_gen (.clock(clock), .reset(reset));

    icache_subsystem u_icache_subsystem (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .mem_arvalid (mem_arvalid),
        .mem_araddr  (mem_araddr),
        .mem_arready (mem_arready),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .mem_rlast   (mem_rlast),
        .mem_rready  (mem_rready),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_ready  (inst_ready),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    // Memory content for a word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return 32'h9e37_79b9 ^ addr;
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    // ------------------------------------------------------------------------
    // Memory model and downstream ready
    // ------------------------------------------------------------------------
    initial begin
        logic        ar_hs;
        logic        r_hs;
        logic        busy;
        logic        b;
        logic [31:0] ar_addr;
        logic [31:0] burst_addr;
        int          beat_idx;
        lfsr        = 32'h321e_36d8;
        busy        = 1'b0;
        beat_idx    = 0;
        burst_addr  = '0;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_rlast   = 1'b0;
        inst_ready  = 1'b1;
        forever begin
            @(negedge clock);
            ar_hs   = mem_arvalid && mem_arready;
            r_hs    = mem_rvalid && mem_rready;
            ar_addr = mem_araddr;
            @(posedge clock);
            #1;
            if (ar_hs) begin
                busy       = 1'b1;
                burst_addr = ar_addr;
                beat_idx   = 0;
            end
            if (r_hs) begin
                beat_idx++;
            end
            if (busy && beat_idx == line_words) begin
                busy = 1'b0;
            end
            b = 1'b1;
            if (stress) draw_bit(b);
            mem_arready = !busy && b;
            b = 1'b1;
            if (stress && busy) draw_bit(b);
            mem_rvalid = busy && b;
            mem_rlast  = busy && (beat_idx == line_words - 1);
            mem_rdata  = busy ? mem_word(burst_addr + 32'(4 * beat_idx)) : '0;
            b = 1'b1;
            if (stress) draw_bit(b);
            inst_ready = b;
        end
    end

    // Compare every delivered instruction with the expected PC and data
    always @(negedge clock) begin
        if (!reset) begin
            if (inst_valid && inst_ready) begin
                if (inst_pc !== exp_pc) begin
                    $display("error at %0t: inst_pc is %h, expected %h", $time, inst_pc, exp_pc);
                    errors++;
                end
                if (inst !== mem_word(exp_pc)) begin
                    $display("error at %0t: inst is %h, expected %h",
                             $time, inst, mem_word(exp_pc));
                    errors++;
                end
                seen++;
                exp_pc = exp_pc + 32'd4;
            end
            if (redirect) begin
                exp_pc = redirect_pc.raw;
            end
        end
    end

    // Redirect, then keep run high until exactly n requests are accepted
    task automatic fetch_block(input logic [31:0] start, input int n);
        int accepted;
        int target;
        accepted = 0;
        target   = seen + n;
        @(posedge clock);
        #1;
        redirect        = 1'b1;
        redirect_pc.raw = start;
        @(posedge clock);
        #1;
        redirect = 1'b0;
        run      = 1'b1;
        while (accepted < n - 1) begin
            @(negedge clock);
            if (u_icache_subsystem.fetch_valid && u_icache_subsystem.fetch_ready) begin
                accepted++;
            end
        end
        @(posedge clock);
        #1;
        run = 1'b0;
        while (seen < target) begin
            @(negedge clock);
        end
    endtask

    task automatic end_test(input int num, input string name, input int hits,
                            input int misses, input int total);
        exp_hits   += hits;
        exp_misses += misses;
        // Idle gap so that a spare instruction would show up
        repeat (10) @(negedge clock);
        if (hit_count !== exp_hits) begin
            $display("error at %0t: hit_count is %0d, expected %0d", $time, hit_count, exp_hits);
            errors++;
        end
        if (miss_count !== exp_misses) begin
            $display("error at %0t: miss_count is %0d, expected %0d",
                     $time, miss_count, exp_misses);
            errors++;
        end
        if (seen != total) begin
            $display("%0d instructions arrived where %0d were expected", seen, total);
            errors++;
        end
        $display("test %0d %s: %s", num, name, (errors == err_mark) ? "ok" : "errors found");
        err_mark = errors;
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    initial begin
        run         = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        flush       = 1'b0;
        stress      = 1'b0;
        exp_pc      = '0;
        seen        = 0;
        errors      = 0;
        err_mark    = 0;
        exp_hits    = 0;
        exp_misses  = 0;
        @(negedge reset);
        @(posedge clock);

        fetch_block(32'h0000_0000, 16);
        end_test(1, "cold sequential fetch", 12, 4, 16);

        fetch_block(32'h0000_0000, 16);
        end_test(2, "warm refetch", 16, 0, 32);

        // 0x40 shares index 0 with address 0
        fetch_block(32'h0000_0040, 4);
        fetch_block(32'h0000_0000, 4);
        end_test(3, "conflict eviction", 6, 2, 40);

        @(posedge clock);
        #1;
        flush = 1'b1;
        @(posedge clock);
        #1;
        flush = 1'b0;
        fetch_block(32'h0000_0000, 16);
        end_test(4, "flush and refetch", 12, 4, 56);

        stress = 1'b1;
        fetch_block(32'h0000_0100, 64);
        stress = 1'b0;
        end_test(5, "random back-pressure", 48, 16, 120);

        $display("tests 5, instructions checked %0d, errors %0d", seen, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(total_insts * 200 * clock_period);
        $display("watchdog timeout at %0t, the instruction stream stopped", $time);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== files.f ====
verilog/icache_pkg.sv
verilog/fetch_sequencer.sv
verilog/icache.sv
verilog/inst_select.sv
verilog/icache_subsystem.sv
sim/tb_clock_gen.sv
sim/tb_icache_subsystem.sv
